/* bus_interface.sv */
/* Data bus driver
   Issues credit-limited memory and I/O cycles and merges all board drives onto IBUS */
`timescale 1ns/100ps
`include "cft_params.svh"

module bus_interface (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rd,
   input  logic              wr,
   input  logic              io,           // I/O space select
   input  logic [15:0]       addr,         // From address register
   input  logic [15:0]       ibus_in,      // Write data
   input  logic              mem_credit,   // Credit return pulse
   input  cft_pkg::mem_rsp_t mem_rsp,
   input  cft_pkg::ibus_t    vec_drive,    // Reset vector
   input  cft_pkg::ibus_t    addr_drive,   // Generated address
   output cft_pkg::mem_req_t mem_req,
   output logic              bus_stall,
   output cft_pkg::ibus_t    ibus_out
);

   localparam int CRED_W = $clog2(`MEM_CREDITS + 1);

   logic [CRED_W-1:0] credits;             // Requests still allowed
   logic              want_bus;            // Microcode asks for a cycle
   logic              issue;               // Request leaves this cycle
   logic              req_valid;
   logic              req_write;
   logic              req_io;
   logic [15:0]       req_addr;
   logic [15:0]       req_wdata;
   logic [15:0]       merged_data;

   //////////////////////////////////////////////////
   // Credits and request issue
   //////////////////////////////////////////////////

   assign want_bus  = rd | wr;
   assign issue     = want_bus && (credits != '0);
   assign bus_stall = want_bus && (credits == '0);  // Microcode holds rd or wr

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits   <= CRED_W'(`MEM_CREDITS);
         req_valid <= 1'b0;
      end else begin
         credits   <= credits - CRED_W'(issue) + CRED_W'(mem_credit);
         req_valid <= issue;               // Single-cycle request
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         req_write <= wr;
         req_io    <= io;
         req_addr  <= addr;
         req_wdata <= ibus_in;
      end
   end

   assign mem_req = '{valid: req_valid, write: req_write, io: req_io,
                      addr: req_addr, wdata: req_wdata};

   //////////////////////////////////////////////////
   // IBUS merge
   //////////////////////////////////////////////////

   // AND-OR merge in place of the wired bus
   assign merged_data = ({16{mem_rsp.valid}}    & mem_rsp.rdata)
                      | ({16{vec_drive.valid}}  & vec_drive.data)
                      | ({16{addr_drive.valid}} & addr_drive.data);

   assign ibus_out = '{valid: mem_rsp.valid | vec_drive.valid | addr_drive.valid,
                       data:  merged_data};

   a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= CRED_W'(`MEM_CREDITS));

   // Read data, reset vector and address generator share IBUS
   a_ibus_one_src: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({mem_rsp.valid, vec_drive.valid, addr_drive.valid}));

endmodule

/* cft_params.svh */
/* CFT processor board constants
   Reset timing, reset vector, memory credits and microcode condition codes */
`ifndef CFT_PARAMS_SVH
`define CFT_PARAMS_SVH

//////////////////////////////////////////////////
// Reset sequencing
//////////////////////////////////////////////////

// Cycles of rsthold after the reset condition goes away
`define RESET_HOLD_CYCLES 8

`define RESET_VECTOR      16'hfff0   // First fetch address

//////////////////////////////////////////////////
// Memory bus
//////////////////////////////////////////////////

`define MEM_CREDITS       2          // Outstanding requests allowed

//////////////////////////////////////////////////
// Microcode condition codes (OPIF field)
//////////////////////////////////////////////////

`define OPIF_NONE         4'h0       // No condition evaluated
`define OPIF_SKIP         4'h1       // Evaluate skip from IR and flags

`endif

/* cft_pkg.sv */
/* CFT processor board types
   Instruction word views, microcode control, flags and bus payloads */
package cft_pkg;

   //////////////////////////////////////////////////
   // Instruction word
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [3:0] op;          // Major opcode
      logic       indirect;    // IR[11] indirection mode
      logic       page;        // 1 = current page, 0 = page zero
      logic [9:0] operand;     // Page offset
   } mem_ref_t;

   typedef struct packed {
      logic [3:0] op;          // Same opcode field
      logic [6:0] spare;
      logic       neg;         // Invert the condition
      logic [3:0] mask;        // Flag select in fn, fz, fl, fv order
   } skip_ir_t;

   // Same IR bits, decoded as memory reference or as skip
   typedef union packed {
      mem_ref_t mref;
      skip_ir_t skp;
   } ir_word_t;

   //////////////////////////////////////////////////
   // Control and status
   //////////////////////////////////////////////////

   typedef struct packed {
      logic       wir;         // Write IR from IBUS
      logic       ragl;        // Generated address onto IBUS
      logic       rd;          // Read cycle
      logic       wr;          // Write cycle
      logic       io;          // I/O space
      logic       sti;         // Set interrupt enable
      logic       cli;         // Clear interrupt enable
      logic       end_instr;   // Instruction boundary
      logic [3:0] opif;        // Condition code
   } ucode_t;

   typedef struct packed {
      logic fn;                // Negative
      logic fz;                // Zero
      logic fl;                // Link
      logic fv;                // Overflow
   } flags_t;

   //////////////////////////////////////////////////
   // Bus payloads
   //////////////////////////////////////////////////

   typedef struct packed {
      logic        valid;
      logic [15:0] data;
   } ibus_t;

   typedef struct packed {
      logic        valid;
      logic        write;      // 1 = write, 0 = read
      logic        io;
      logic [15:0] addr;
      logic [15:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] rdata;
   } mem_rsp_t;

endpackage

/* instr_addr_unit.sv */
/* Instruction register and address generation
   Latches IR from IBUS and forms page-relative or zero-page operand addresses */
`timescale 1ns/100ps

module instr_addr_unit (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wir,          // Load IR from IBUS
   input  logic              ragl,         // Drive generated address
   input  logic [15:0]       ibus_in,
   input  logic [5:0]        pc_hi,        // PC[15:10]
   output cft_pkg::ir_word_t ir,
   output cft_pkg::ibus_t    addr_drive
);

   logic [5:0]  page_bits;                 // Upper address bits
   logic [15:0] gen_addr;                  // Full operand address

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ir <= '0;
      end else if (wir) begin
         ir <= ibus_in;                    // Whole word, both views
      end
   end

   // Current page keeps PC high bits, page zero forces them clear
   assign page_bits = ir.mref.page ? pc_hi : 6'b000000;
   assign gen_addr  = {page_bits, ir.mref.operand};

   assign addr_drive = '{valid: ragl, data: gen_addr};  // Same-cycle drive

   // Loading IR while reading from it would race on IBUS
   a_wir_ragl_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(wir && ragl));

endmodule

/* int_state.sv */
/* Interrupt state machine
   Keeps interrupt enable, registers FIRQ and acknowledges at instruction boundaries */
`timescale 1ns/100ps

module int_state (
   input  logic clk,
   input  logic rst_n,
   input  logic sti,                       // Enable interrupts
   input  logic cli,                       // Disable interrupts
   input  logic irq,                       // Request from the bus
   input  logic end_instr,
   output logic firq,                      // Interrupt pending
   output logic irq_ack                    // Acknowledge strobe
);

   logic int_en;                           // Interrupt enable
   logic take_int;                         // Boundary with a pending IRQ

   assign take_int = end_instr & firq;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         int_en  <= 1'b0;
         firq    <= 1'b0;
         irq_ack <= 1'b0;
      end else begin
         irq_ack <= take_int;              // One cycle only
         firq    <= int_en & irq & ~take_int;  // Ack consumes the request
         if (take_int || cli) begin
            int_en <= 1'b0;                // Handler entry masks further IRQs
         end else if (sti) begin
            int_en <= 1'b1;
         end
      end
   end

   // Conflicting enable commands from microcode
   a_sti_cli_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(sti && cli));

endmodule

/* proc_board.sv */
/* CFT processor board top level
   IR, address generation, skip, interrupts, reset sequencing and bus driver */
`timescale 1ns/100ps

module proc_board (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              fp_reset,     // Front-panel reset
   input  cft_pkg::ucode_t   ucode,        // Microcode control word
   input  cft_pkg::flags_t   flags,        // Datapath flags
   input  logic [15:0]       ibus_in,
   input  logic [5:0]        pc_hi,        // PC[15:10]
   input  logic [15:0]       addr,         // Address register
   input  logic              irq,
   input  logic              skip_ext,
   input  cft_pkg::mem_rsp_t mem_rsp,
   input  logic              mem_credit,
   output cft_pkg::ir_word_t ir,           // Also shown on the front panel
   output cft_pkg::ibus_t    ibus_out,
   output logic              skip,
   output logic              firq,         // Also shown on the front panel
   output logic              irq_ack,
   output logic              rsthold,
   output logic              bus_stall,
   output cft_pkg::mem_req_t mem_req
);
   import cft_pkg::*;

   //////////////////////////////////////////////////
   // Wires between blocks
   //////////////////////////////////////////////////

   ibus_t vec_drive;                       // Reset vector drive
   ibus_t addr_drive;                      // Generated address drive

   //////////////////////////////////////////////////
   // Reset sequencing and vector
   //////////////////////////////////////////////////

   reset_seq rst_seq (.clk(clk), .rst_n(rst_n), .fp_reset(fp_reset),
                      .rsthold(rsthold), .vec_drive(vec_drive));

   //////////////////////////////////////////////////
   // Instruction register and address generation
   //////////////////////////////////////////////////

   instr_addr_unit agl_ir (.clk(clk), .rst_n(rst_n),
                           .wir(ucode.wir), .ragl(ucode.ragl),
                           .ibus_in(ibus_in), .pc_hi(pc_hi),
                           .ir(ir), .addr_drive(addr_drive));

   //////////////////////////////////////////////////
   // Skip logic
   //////////////////////////////////////////////////

   skip_logic sbl (.clk(clk), .rst_n(rst_n), .ir(ir), .flags(flags),
                   .opif(ucode.opif), .skip_ext(skip_ext),
                   .end_instr(ucode.end_instr), .skip(skip));

   //////////////////////////////////////////////////
   // Interrupt state machine
   //////////////////////////////////////////////////

   int_state ism (.clk(clk), .rst_n(rst_n), .sti(ucode.sti), .cli(ucode.cli),
                  .irq(irq), .end_instr(ucode.end_instr),
                  .firq(firq), .irq_ack(irq_ack));

   //////////////////////////////////////////////////
   // Bus driver
   //////////////////////////////////////////////////

   bus_interface dbd (.clk(clk), .rst_n(rst_n),
                      .rd(ucode.rd), .wr(ucode.wr), .io(ucode.io),
                      .addr(addr), .ibus_in(ibus_in), .mem_credit(mem_credit),
                      .mem_rsp(mem_rsp), .vec_drive(vec_drive),
                      .addr_drive(addr_drive), .mem_req(mem_req),
                      .bus_stall(bus_stall), .ibus_out(ibus_out));

endmodule

/* reset_seq.sv */
/* Reset sequencer
   Holds the board in reset for a fixed count, then drives the reset vector once */
`timescale 1ns/100ps
`include "cft_params.svh"

module reset_seq (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           fp_reset,      // Front-panel reset switch
   output logic           rsthold,       // Board held in reset
   output cft_pkg::ibus_t vec_drive      // Reset vector onto IBUS
);

   localparam int HOLD_W = $clog2(`RESET_HOLD_CYCLES + 1);

   logic [HOLD_W-1:0] hold_cnt;          // Remaining hold cycles
   logic              vec_pulse;         // One-shot vector strobe

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hold_cnt  <= HOLD_W'(`RESET_HOLD_CYCLES);
         vec_pulse <= 1'b0;
      end else if (fp_reset) begin
         hold_cnt  <= HOLD_W'(`RESET_HOLD_CYCLES);  // Restart from the top
         vec_pulse <= 1'b0;
      end else begin
         if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
         end
         vec_pulse <= (hold_cnt == HOLD_W'(1));    // Count just expiring
      end
   end

   assign rsthold   = (hold_cnt != '0);
   assign vec_drive = '{valid: vec_pulse, data: `RESET_VECTOR};

   // Vector must be a single IBUS beat per reset
   a_vec_one_shot: assert property (@(posedge clk) disable iff (!rst_n)
      vec_drive.valid |=> !vec_drive.valid);

endmodule

/* skip_logic.sv */
/* Skip and branch logic
   Tests masked flags against the IR skip field and holds the result to end of instruction */
`timescale 1ns/100ps
`include "cft_params.svh"

module skip_logic (
   input  logic              clk,
   input  logic              rst_n,
   input  cft_pkg::ir_word_t ir,
   input  cft_pkg::flags_t   flags,
   input  logic [3:0]        opif,         // Microcode condition code
   input  logic              skip_ext,     // Skip request from the bus
   input  logic              end_instr,
   output logic              skip
);

   logic [3:0] sel_flags;                  // Flags picked by the mask
   logic       cond_true;                  // Skip test result
   logic       skip_set;                   // Any skip source this cycle

   assign sel_flags = ir.skp.mask & flags;

   always_comb begin
      case (opif)
         `OPIF_NONE: cond_true = 1'b0;
         `OPIF_SKIP: cond_true = (|sel_flags) ^ ir.skp.neg;
         default:    cond_true = 1'b0;     // Other codes belong elsewhere
      endcase
   end

   assign skip_set = cond_true | skip_ext;

   // A new request wins over the end-of-instruction clear
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         skip <= 1'b0;
      end else if (skip_set) begin
         skip <= 1'b1;
      end else if (end_instr) begin
         skip <= 1'b0;
      end
   end

endmodule

/* src.f */
+incdir+.
cft_pkg.sv
reset_seq.sv
instr_addr_unit.sv
skip_logic.sv
int_state.sv
bus_interface.sv
proc_board.sv
tb_proc_board.sv

/* tb_proc_board.sv */
/* Processor board testbench
   Table-driven stimulus with a credit-returning memory model */
`timescale 1ns/100ps
`include "cft_params.svh"

module tb_proc_board;
   import cft_pkg::*;

   localparam int TABLE_LEN      = 40;
   localparam int TIMEOUT_CYCLES = (TABLE_LEN + `RESET_HOLD_CYCLES + 64) * 4;

   // Microcode words in wir, ragl, rd, wr, io, sti, cli, end, opif order
   localparam ucode_t UC_IDLE = 12'h000;
   localparam ucode_t UC_WIR  = 12'h800;
   localparam ucode_t UC_RAGL = 12'h400;
   localparam ucode_t UC_RD   = 12'h200;
   localparam ucode_t UC_WR   = 12'h100;
   localparam ucode_t UC_IORD = 12'h280;
   localparam ucode_t UC_IOWR = 12'h180;
   localparam ucode_t UC_STI  = 12'h040;
   localparam ucode_t UC_CLI  = 12'h020;
   localparam ucode_t UC_END  = 12'h010;
   localparam ucode_t UC_SKIP = {8'h00, `OPIF_SKIP};
   localparam ibus_t  NO_IB   = 17'h0;

   typedef struct packed {
      ucode_t      uc;
      logic [15:0] ibus_in;
      flags_t      flags;
      logic [5:0]  pc_hi;
      logic [15:0] addr;
      logic        irq;
      logic        skip_ext;
      ibus_t       exp_ibus;       // Board drive, read data excluded
      logic        exp_skip;
      logic        exp_firq;
      logic        exp_ack;
   } row_t;

   logic        clk, rst_n, fp_reset, irq, skip_ext, mem_credit;
   ucode_t      ucode;
   flags_t      flags;
   logic [15:0] ibus_in, addr;
   logic [5:0]  pc_hi;
   mem_rsp_t    mem_rsp;
   ir_word_t    ir;
   ibus_t       ibus_out;
   logic        skip, firq, irq_ack, rsthold, bus_stall;
   mem_req_t    mem_req;

   row_t        table_rows [TABLE_LEN];
   int          row_count    = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycle_count  = 0;
   int          avail        = `MEM_CREDITS;  // Credit count seen by the board
   int          outstanding  = 0;             // Requests not yet credited back
   logic        exp_stall    = 1'b0;
   logic        stall_seen   = 1'b0;
   ibus_t       rsp_exp      = '0;            // Read data due this cycle
   logic [15:0] exp_ir       = 16'h0000;
   mem_req_t    exp_req_q [$];
   int          credit_due_q [$];
   integer      seed;
   mem_req_t    got_exp;
   logic        drained;                      // No request or credit pending

   proc_board dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      value_errors++;
      $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
   endtask

   task automatic add_row(input ucode_t uc, input logic [15:0] ib, input flags_t fl,
                          input logic [5:0] ph, input logic [15:0] ad, input logic rq,
                          input logic sx, input ibus_t e_ib, input logic e_sk,
                          input logic e_fq, input logic e_ak);
      if (row_count < TABLE_LEN) begin
         table_rows[row_count] = {uc, ib, fl, ph, ad, rq, sx, e_ib, e_sk, e_fq, e_ak};
      end
      row_count++;
   endtask

   task automatic drive_row(input row_t r);
      ucode    = r.uc;
      ibus_in  = r.ibus_in;
      flags    = r.flags;
      pc_hi    = r.pc_hi;
      addr     = r.addr;
      irq      = r.irq;
      skip_ext = r.skip_ext;
   endtask

   task automatic next_drive_point;
      @(posedge clk);
      #1;                                // Inputs change 1 ns after the edge
   endtask

   // Reference credit count, stall and request expectation
   task automatic sample_point;
      logic     want;
      mem_req_t nr;
      #2;
      want      = ucode.rd | ucode.wr;
      exp_stall = want && (avail == 0);
      if (bus_stall !== exp_stall) report_mismatch("bus_stall", bus_stall, exp_stall);
      if (bus_stall === 1'b1) stall_seen = 1'b1;
      if (want && !exp_stall) begin
         nr.valid = 1'b1;
         nr.write = ucode.wr;
         nr.io    = ucode.io;
         nr.addr  = addr;
         nr.wdata = ibus_in;
         exp_req_q.push_back(nr);
         avail--;
      end
      if (mem_credit) avail++;           // Usable from the next cycle
   endtask

   task automatic check_reset_sequence(input logic power_on);
      int i;
      for (i = 0; i < `RESET_HOLD_CYCLES; i++) begin
         sample_point;
         if (rsthold !== 1'b1) begin
            other_errors++;
            $display("rsthold dropped in hold cycle %0d at %0t", i, $time);
         end
         if (ibus_out.valid !== 1'b0) report_mismatch("ibus_out.valid", ibus_out.valid, 0);
         if (power_on) begin
            if (mem_req.valid !== 1'b0) report_mismatch("mem_req.valid", mem_req.valid, 0);
            if (skip !== 1'b0) report_mismatch("skip", skip, 0);
            if (firq !== 1'b0) report_mismatch("firq", firq, 0);
            if (irq_ack !== 1'b0) report_mismatch("irq_ack", irq_ack, 0);
         end
         next_drive_point;
      end
      sample_point;
      if (rsthold !== 1'b0) begin
         other_errors++;
         $display("rsthold still high after the hold count at %0t", $time);
      end
      if (ibus_out !== {1'b1, `RESET_VECTOR}) report_mismatch("ibus_out", ibus_out,
                                                              {1'b1, `RESET_VECTOR});
      next_drive_point;
      sample_point;
      if (ibus_out.valid !== 1'b0) report_mismatch("ibus_out.valid", ibus_out.valid, 0);
      next_drive_point;
   endtask

   task automatic check_row(input row_t r);
      ibus_t exp_ib;
      exp_ib = rsp_exp.valid ? rsp_exp : r.exp_ibus;  // Read data takes the bus
      if (ir !== exp_ir) report_mismatch("ir", ir, exp_ir);
      if (ibus_out.valid !== exp_ib.valid || (exp_ib.valid && ibus_out.data !== exp_ib.data))
         report_mismatch("ibus_out", ibus_out, exp_ib);
      if (skip !== r.exp_skip) report_mismatch("skip", skip, r.exp_skip);
      if (firq !== r.exp_firq) report_mismatch("firq", firq, r.exp_firq);
      if (irq_ack !== r.exp_ack) report_mismatch("irq_ack", irq_ack, r.exp_ack);
   endtask

   //////////////////////////////////////////////////
   // Memory model
   //////////////////////////////////////////////////

   initial begin
      seed       = 32'h88c3;
      mem_rsp    = '0;
      mem_credit = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         mem_rsp    = '0;
         mem_credit = 1'b0;
         rsp_exp    = '0;
         if (mem_req.valid === 1'b1) begin
            if (exp_req_q.size() == 0) begin
               other_errors++;
               $display("Memory request issued with none expected at %0t", $time);
            end else begin
               got_exp = exp_req_q.pop_front();
               if (mem_req.write !== got_exp.write)
                  report_mismatch("mem_req.write", mem_req.write, got_exp.write);
               if (mem_req.io !== got_exp.io)
                  report_mismatch("mem_req.io", mem_req.io, got_exp.io);
               if (mem_req.addr !== got_exp.addr)
                  report_mismatch("mem_req.addr", mem_req.addr, got_exp.addr);
               if (mem_req.wdata !== got_exp.wdata)
                  report_mismatch("mem_req.wdata", mem_req.wdata, got_exp.wdata);
               if (!got_exp.write) rsp_exp = {1'b1, got_exp.addr ^ 16'h5a5a};
            end
            if (mem_req.write === 1'b0) mem_rsp = {1'b1, mem_req.addr ^ 16'h5a5a};
            credit_due_q.push_back(cycle_count + ($random(seed) & 3) + 1);  // 1 to 4
            outstanding++;
            if (outstanding > `MEM_CREDITS) begin
               other_errors++;
               $display("More than %0d requests outstanding at %0t", `MEM_CREDITS, $time);
            end
         end else if (exp_req_q.size() != 0) begin
            other_errors++;
            $display("Expected memory request was not issued at %0t", $time);
            got_exp = exp_req_q.pop_front();
         end
         if (credit_due_q.size() != 0 && credit_due_q[0] <= cycle_count) begin
            mem_credit = 1'b1;           // One credit per cycle at most
            void'(credit_due_q.pop_front());
            outstanding--;
         end
      end
   end

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("Timeout after %0d cycles, the run did not complete", cycle_count);
      $display("TB FAILED");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus table and main sequence
   //////////////////////////////////////////////////

   initial begin
      rst_n    = 1'b0;
      fp_reset = 1'b0;
      drive_row('0);
      // IR load, current page then page zero
      add_row(UC_WIR,  16'h5523, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_RAGL, 16'h0000, 4'h0, 6'h2a, 16'h0000, 0, 0, {1'b1, 16'ha923}, 0, 0, 0);
      add_row(UC_WIR,  16'h3987, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_RAGL, 16'h0000, 4'h0, 6'h3f, 16'h0000, 0, 0, {1'b1, 16'h0187}, 0, 0, 0);
      // Skip on fz, then negated fn or fv, then external
      add_row(UC_WIR,  16'h7004, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_SKIP, 16'h0000, 4'h4, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 1, 0, 0);
      add_row(UC_END,  16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 1, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_SKIP, 16'h0000, 4'hb, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_WIR,  16'h7019, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_SKIP, 16'h0000, 4'h6, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_END,  16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 1, 0, 0);
      add_row(UC_SKIP, 16'h0000, 4'h8, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 1, NO_IB, 0, 0, 0);
      add_row(UC_END,  16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 1, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      // Interrupt taken at a boundary, then masked by cli
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 0, 0);
      add_row(UC_STI,  16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 1, 0);
      add_row(UC_END,  16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 1, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 0, 1);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 0, 0);
      add_row(UC_STI,  16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_CLI,  16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 1, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      // Back-to-back cycles, the third read must stall
      add_row(UC_RD,   16'h0000, 4'h0, 6'h00, 16'h1234, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_RD,   16'h0000, 4'h0, 6'h00, 16'h2345, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_RD,   16'h0000, 4'h0, 6'h00, 16'h3456, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_WR,   16'hbeef, 4'h0, 6'h00, 16'h4567, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IORD, 16'h0000, 4'h0, 6'h00, 16'h00f3, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IOWR, 16'h0c0d, 4'h0, 6'h00, 16'h0011, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      add_row(UC_IDLE, 16'h0000, 4'h0, 6'h00, 16'h0000, 0, 0, NO_IB, 0, 0, 0);
      if (row_count != TABLE_LEN) begin
         other_errors++;
         $display("Stimulus table holds %0d rows instead of %0d", row_count, TABLE_LEN);
      end

      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_reset_sequence(1'b1);

      for (int i = 0; i < TABLE_LEN; i++) begin
         do begin
            drive_row(table_rows[i]);
            sample_point;
            check_row(table_rows[i]);
            next_drive_point;
         end while (exp_stall);         // Microcode holds rd or wr
         if (table_rows[i].uc.wir) exp_ir = table_rows[i].ibus_in;
      end

      drive_row('0);
      do begin
         sample_point;
         drained = (outstanding == 0 && exp_req_q.size() == 0);
         next_drive_point;
      end while (!drained);
      if (!stall_seen) begin
         other_errors++;
         $display("bus_stall never rose with all credits outstanding");
      end

      fp_reset = 1'b1;                   // Front-panel restart
      sample_point;
      next_drive_point;
      fp_reset = 1'b0;
      check_reset_sequence(1'b0);

      $display("Errors: %0d value mismatches, %0d other failures",
               value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
